/* list.f */
i2cPkg.sv
i2cBusSense.sv
i2cSlaveIf.sv
i2cRegWriter.sv
i2cSlaveTop.sv
tbClkGen.sv
tbI2cTop.sv

/* tbI2cTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests: bit-bang I2C master, open-drain SDA, bank model, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tbI2cTop import i2cPkg::*;
();

localparam logic [6:0] lpSlave  = 7'h3a;
localparam int         lpHalf   = 40;				// Clocks per SCL half period
localparam int         lpWdClks = 6 * 40 * 720 * 2;	// Tests x bytes x clocks, 2x margin

logic               clk;
logic               rst;
logic               sclDrv;				// Master drives, open drain
logic               sdaDrv;
logic               sdaOe;
logic               sdaBus;
logic [lpRegAw-1:0] rdAdrs;
logic [7:0]         rdData;
logic [7:0]         model [lpRegNum];	// Expected bank contents
int                 modelPtr;
logic [7:0]         txQ [$];			// Data bytes of the next transfer
logic [31:0]        lcgState;
int                 errCnt;
int                 testCnt;
int                 passCnt;

assign sdaBus = sdaDrv & ~sdaOe;		// Wired AND with the slave pull-down

tbClkGen uClkGen
(
	.clk (clk),
	.rst (rst)
);

i2cSlaveTop i_dut
(
	.iCLK       (clk),
	.iRST       (rst),
	.iScl       (sclDrv),
	.iSda       (sdaBus),
	.oSdaOe     (sdaOe),
	.iSlaveAdrs (lpSlave),
	.iRdAdrs    (rdAdrs),
	.oRdData    (rdData)
);

task automatic waitClk(input int n);
	repeat (n) @(negedge clk);
endtask

function automatic logic [7:0] lcgByte();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState[23:16];			// Middle bits, better spread
endfunction

function automatic i2cByteU mkAdr(input logic [6:0] adrs, input logic rd);
	i2cByteU b;
	b.adr.adrs = adrs;
	b.adr.rd   = rd;
	return b;
endfunction

task automatic busStart();
	waitClk(lpHalf);				// Bus free time
	sdaDrv = 1'b0;					// SDA falls while SCL high
	waitClk(lpHalf);
	sclDrv = 1'b0;
endtask

task automatic busStop();
	waitClk(lpHalf / 2);
	sdaDrv = 1'b0;
	waitClk(lpHalf / 2);
	sclDrv = 1'b1;
	waitClk(lpHalf);
	sdaDrv = 1'b1;					// SDA rises while SCL high
	waitClk(lpHalf);
endtask

// One SCL clock, SDA changed mid low phase, slave OE sampled mid high phase
task automatic clockBit(input logic b, output logic oe);
	waitClk(lpHalf / 2);
	sdaDrv = b;
	waitClk(lpHalf / 2);
	sclDrv = 1'b1;
	waitClk(lpHalf / 2);
	oe = sdaOe;
	waitClk(lpHalf / 2);
	sclDrv = 1'b0;
endtask

task automatic sendBits(input logic [7:0] data, input int n);
	logic oe;
	for (int i = 0; i < n; i++)
		clockBit(data[7 - i], oe);		// MSB first
endtask

task automatic sendByte(input logic [7:0] data, output logic ack);
	sendBits(data, 8);
	clockBit(1'b1, ack);				// Released SDA, 9th clock
endtask

task automatic checkAck(input logic got, input logic exp, input string what);
	if (got !== exp)
	begin
		errCnt++;
		$display("Error at %0t: ACK on %s byte was %0b, expected %0b", $time, what, got, exp);
	end
endtask

task automatic checkReg(input logic [lpRegAw-1:0] adrs, input logic [7:0] exp);
	rdAdrs = adrs;
	waitClk(2);
	if (rdData !== exp)
	begin
		errCnt++;
		$display("Error at %0t: register %0d read %02h, expected %02h",
			$time, adrs, rdData, exp);
	end
endtask

task automatic checkAll();
	for (int i = 0; i < lpRegNum; i++)
		checkReg(lpRegAw'(i), model[i]);
endtask

// Full write transfer, pointer then txQ; model follows only when addressed
task automatic writeXfer(input i2cByteU adr, input logic [7:0] ptr);
	logic ack;
	logic hit;
	hit = (adr.adr.adrs == lpSlave) && !adr.adr.rd;
	busStart();
	sendByte(adr.raw, ack);
	checkAck(ack, hit, "address");
	sendByte(ptr, ack);
	checkAck(ack, hit, "pointer");
	if (hit)
		modelPtr = ptr % lpRegNum;
	for (int i = 0; i < txQ.size(); i++)
	begin
		sendByte(txQ[i], ack);
		checkAck(ack, hit, "data");
		if (hit)
		begin
			model[modelPtr] = txQ[i];
			modelPtr = (modelPtr + 1) % lpRegNum;	// Wraps with the bank
		end
	end
	busStop();
endtask

task automatic endTest(input string name, input int errBefore);
	testCnt++;
	if (errCnt == errBefore)
	begin
		passCnt++;
		$display("%0t %s: ok", $time, name);
	end
	else
		$display("%0t %s: %0d errors", $time, name, errCnt - errBefore);
endtask

task automatic testSingle();
	int e0;
	e0 = errCnt;
	txQ.delete();
	txQ.push_back(8'ha5);
	writeXfer(mkAdr(lpSlave, 1'b0), 8'd5);
	checkReg(4'd5, 8'ha5);
	endTest("single write", e0);
endtask

task automatic testBurstWrap();
	int e0;
	e0 = errCnt;
	txQ.delete();
	repeat (4) txQ.push_back(lcgByte());
	writeXfer(mkAdr(lpSlave, 1'b0), 8'd14);
	checkReg(4'd14, txQ[0]);
	checkReg(4'd15, txQ[1]);
	checkReg(4'd0, txQ[2]);				// Pointer wrapped
	checkReg(4'd1, txQ[3]);
	endTest("burst with wrap", e0);
endtask

task automatic testWrongAdrs();
	int e0;
	e0 = errCnt;
	txQ.delete();
	repeat (2) txQ.push_back(lcgByte());
	writeXfer(mkAdr(7'h3b, 1'b0), 8'd3);
	checkAll();
	endTest("wrong address", e0);
endtask

task automatic testReadFlag();
	int e0;
	e0 = errCnt;
	txQ.delete();
	txQ.push_back(lcgByte());
	writeXfer(mkAdr(lpSlave, 1'b1), 8'd2);
	checkAll();
	endTest("read flag set", e0);
endtask

task automatic testStopMidByte();
	int      e0;
	logic    ack;
	i2cByteU adr;
	e0  = errCnt;
	adr = mkAdr(lpSlave, 1'b0);
	busStart();
	sendByte(adr.raw, ack);
	checkAck(ack, 1'b1, "address");
	sendByte(8'd7, ack);
	checkAck(ack, 1'b1, "pointer");
	sendBits(8'h5c, 4);					// Half a data byte, then stop
	busStop();
	checkAll();
	txQ.delete();
	txQ.push_back(8'h3c);
	writeXfer(adr, 8'd9);
	checkReg(4'd9, 8'h3c);
	checkAll();
	endTest("stop mid byte", e0);
endtask

task automatic testRandomBurst();
	int         e0;
	logic [7:0] ptr;
	e0  = errCnt;
	ptr = lcgByte();					// Upper bits ignored by the slave
	txQ.delete();
	repeat (24) txQ.push_back(lcgByte());
	writeXfer(mkAdr(lpSlave, 1'b0), ptr);
	checkAll();
	endTest("random burst", e0);
endtask

// Watchdog
initial
begin
	repeat (lpWdClks) @(posedge clk);
	$display("Timeout: the tests did not finish within %0d clocks", lpWdClks);
	$display("SIMULATION FAILED");
	$finish;
end

initial
begin
	sclDrv   = 1'b1;					// Idle bus
	sdaDrv   = 1'b1;
	rdAdrs   = '0;
	lcgState = 32'h971f5881;
	errCnt   = 0;
	testCnt  = 0;
	passCnt  = 0;
	modelPtr = 0;
	for (int i = 0; i < lpRegNum; i++)
		model[i] = 8'h00;				// Bank clears on reset
	@(negedge clk);
	while (rst)
		@(negedge clk);
	waitClk(4);

	testSingle();
	testBurstWrap();
	testWrongAdrs();
	testReadFlag();
	testStopMidByte();
	testRandomBurst();

	$display("Tests run %0d, passed %0d, check errors %0d", testCnt, passCnt, errCnt);
	if (errCnt == 0)
		$display("SIMULATION PASSED");
	else
		$display("SIMULATION FAILED");
	$finish;
end

endmodule

`default_nettype wire

/* tbClkGen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock, period 8, with reset held for 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tbClkGen
(
	output logic clk,
	output logic rst
);

initial
begin
	clk = 1'b0;
	forever
		#4 clk = ~clk;			// Period 8
end

initial
begin
	rst = 1'b1;
	repeat (4) @(posedge clk);
	@(negedge clk);
	rst = 1'b0;					// Released away from the active edge
end

endmodule

`default_nettype wire

/* i2cSlaveTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-only I2C slave top with bus sensing, slave interface, register bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module i2cSlaveTop import i2cPkg::*;
(
	input  logic               iCLK,
	input  logic               iRST,
	input  logic               iScl,
	input  logic               iSda,
	output logic               oSdaOe,		// High pulls SDA low
	input  logic [6:0]         iSlaveAdrs,
	input  logic [lpRegAw-1:0] iRdAdrs,
	output logic [7:0]         oRdData
);

busEventS busEvent;			// Synced strobes and bus state
logic     xferReq;
logic     xferAck;
byteXferS xfer;				// Decoded byte to the bank

i2cBusSense uBusSense
(
	.iCLK     (iCLK),
	.iRST     (iRST),
	.iScl     (iScl),
	.iSda     (iSda),
	.busEvent (busEvent)
);

i2cSlaveIf uSlaveIf
(
	.iCLK       (iCLK),
	.iRST       (iRST),
	.busEvent   (busEvent),
	.iSlaveAdrs (iSlaveAdrs),
	.oSdaOe     (oSdaOe),
	.xferReq    (xferReq),
	.xfer       (xfer),
	.xferAck    (xferAck)
);

i2cRegWriter uRegWriter
(
	.iCLK    (iCLK),
	.iRST    (iRST),
	.xferReq (xferReq),
	.xfer    (xfer),
	.xferAck (xferAck),
	.iRdAdrs (iRdAdrs),
	.oRdData (oRdData)
);

endmodule

`default_nettype wire

/* i2cRegWriter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte ack side, register pointer, register bank and registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module i2cRegWriter import i2cPkg::*;
(
	input  logic               iCLK,
	input  logic               iRST,
	input  logic               xferReq,
	input  byteXferS           xfer,
	output logic               xferAck,
	input  logic [lpRegAw-1:0] iRdAdrs,
	output logic [7:0]         oRdData
);

logic               rAck;
logic               qAccept;			// New req seen with ack low
logic [lpRegAw-1:0] rPtr;
logic [7:0]         rBank [lpRegNum];
logic [7:0]         rRdData;

assign qAccept = xferReq & ~rAck;

always_ff @(posedge iCLK)
begin
	if (iRST)
	begin
		rAck <= 1'b0;
		rPtr <= '0;
		for (int i = 0; i < lpRegNum; i++)
			rBank[i] <= 8'h00;			// Bank starts cleared
	end
	else
	begin
		// Four-phase ack side
		if (qAccept)			rAck <= 1'b1;
		else if (!xferReq)		rAck <= 1'b0;

		if (qAccept)
		begin
			if (xfer.first)
				rPtr <= xfer.data[lpRegAw-1:0];		// Pointer byte, low bits only
			else
			begin
				rBank[rPtr] <= xfer.data;
				// Auto-increment, wrap at bank end
				if (rPtr == lpRegAw'(lpRegNum - 1))
					rPtr <= '0;
				else
					rPtr <= rPtr + 1'b1;
			end
		end
	end
end

// Read port, one clock latency
always_ff @(posedge iCLK)
begin
	rRdData <= rBank[iRdAdrs];
end

assign xferAck = rAck;
assign oRdData = rRdData;

endmodule

`default_nettype wire

/* i2cSlaveIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit counter, byte shifter, address match, delayed ACK drive, byte req side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module i2cSlaveIf import i2cPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST,
	input  busEventS   busEvent,
	input  logic [6:0] iSlaveAdrs,
	output logic       oSdaOe,
	output logic       xferReq,
	output byteXferS   xfer,
	input  logic       xferAck
);

logic [3:0]         rBitCnt;		// Counts 0..8 with 8 as the ACK clock
i2cByteU            rShift;
i2cByteU            qByte;			// Byte including the current bit
logic               qByteDone;		// 8th rising strobe
logic               qDataDone;
logic               rAdrPhase;		// Next byte is the address byte
logic               rAddressed;
logic               rPtrNext;		// Next data byte is the pointer
logic               rAckArm;
logic [lpHoldW-1:0] rHoldCnt;
logic               rHoldRun;
logic               qHoldStart;
logic               rSdaOe;
logic               rReq;
byteXferS           rXfer;

always_comb
begin
	qByte.raw  = {rShift.raw[6:0], busEvent.sda};		// MSB first
	qByteDone  = busEvent.busActive & busEvent.sclRise
		& (rBitCnt == 4'(lpByteBits - 1));
	qDataDone  = qByteDone & rAddressed;
	// SCL fall after an armed 8th bit or at the end of the ACK clock
	qHoldStart = busEvent.busActive & busEvent.sclFall
		& ((rAckArm & (rBitCnt == 4'(lpByteBits))) | rSdaOe);
end

// Shift register and handoff data
always_ff @(posedge iCLK)
begin
	if (busEvent.sclRise && rBitCnt != 4'(lpByteBits))
		rShift <= qByte;
	if (qDataDone)
	begin
		rXfer.first <= rPtrNext;
		rXfer.data  <= qByte.raw;
	end
end

always_ff @(posedge iCLK)
begin
	if (iRST || !busEvent.busActive)		// Stop or reset drops the transfer
	begin
		rBitCnt    <= 4'd0;
		rAdrPhase  <= 1'b1;
		rAddressed <= 1'b0;
		rPtrNext   <= 1'b0;
		rAckArm    <= 1'b0;
		rHoldCnt   <= '0;
		rHoldRun   <= 1'b0;
		rSdaOe     <= 1'b0;
	end
	else
	begin
		if (busEvent.sclRise)
			rBitCnt <= (rBitCnt == 4'(lpByteBits)) ? 4'd0 : rBitCnt + 4'd1;

		if (qByteDone)
		begin
			rAckArm <= 1'b0;
			if (rAdrPhase)
			begin
				rAdrPhase <= 1'b0;
				// Write to our address only
				if (qByte.adr.adrs == iSlaveAdrs && !qByte.adr.rd)
				begin
					rAddressed <= 1'b1;
					rPtrNext   <= 1'b1;
					rAckArm    <= 1'b1;
				end
			end
			else if (rAddressed)
			begin
				rPtrNext <= 1'b0;
				rAckArm  <= 1'b1;			// Every data byte is ACKed
			end
		end
		else if (qHoldStart)
			rAckArm <= 1'b0;

		// SDA hold delay after SCL fall
		if (qHoldStart)
		begin
			rHoldRun <= 1'b1;
			rHoldCnt <= lpHoldW'(1);
		end
		else if (rHoldRun)
		begin
			if (rHoldCnt == lpHoldW'(lpSdaHold - 1))
			begin
				rSdaOe   <= ~rSdaOe;		// Assert or release ACK
				rHoldRun <= 1'b0;
			end
			else
				rHoldCnt <= rHoldCnt + 1'b1;
		end
	end
end

// Byte handoff runs to completion across a stop
always_ff @(posedge iCLK)
begin
	if (iRST)				rReq <= 1'b0;
	else if (qDataDone)		rReq <= 1'b1;
	else if (xferAck)		rReq <= 1'b0;
end

assign oSdaOe  = rSdaOe;
assign xferReq = rReq;
assign xfer    = rXfer;

// Writer must have finished the last byte before the next one completes
aReqFree: assert property (@(posedge iCLK) disable iff (iRST)
	qDataDone |-> !rReq);

// Req rises only after the previous ack has dropped
aReqOrder: assert property (@(posedge iCLK) disable iff (iRST)
	$rose(rReq) |-> !xferAck);

// No SDA drive while the bus is idle
aOeIdle: assert property (@(posedge iCLK) disable iff (iRST)
	!busEvent.busActive |-> !rSdaOe);

endmodule

`default_nettype wire

/* i2cBusSense.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCL/SDA synchronizers, SCL edge strobes, start/stop detection, bus state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module i2cBusSense import i2cPkg::*;
(
	input  logic     iCLK,
	input  logic     iRST,
	input  logic     iScl,
	input  logic     iSda,
	output busEventS busEvent
);

logic [1:0] rSclSync, rSdaSync;		// Two-flop synchronizers
logic       rSclPrev, rSdaPrev;		// One-deep history per line
logic       qSclS, qSdaS;
logic       qStart, qStop;
busEventS   rEvent;

always_comb
begin
	qSclS  = rSclSync[1];
	qSdaS  = rSdaSync[1];
	// SDA edge while SCL stays high
	qStart = qSclS & rSclPrev &  rSdaPrev & ~qSdaS;	// SDA H -> L
	qStop  = qSclS & rSclPrev & ~rSdaPrev &  qSdaS;	// SDA L -> H
end

always_ff @(posedge iCLK)
begin
	if (iRST)
	begin
		rSclSync         <= 2'b11;		// Idle bus reads high
		rSdaSync         <= 2'b11;
		rSclPrev         <= 1'b1;
		rSdaPrev         <= 1'b1;
		rEvent.sclRise   <= 1'b0;
		rEvent.sclFall   <= 1'b0;
		rEvent.sda       <= 1'b1;
		rEvent.busActive <= 1'b0;
	end
	else
	begin
		rSclSync <= {rSclSync[0], iScl};
		rSdaSync <= {rSdaSync[0], iSda};
		rSclPrev <= qSclS;
		rSdaPrev <= qSdaS;

		// Edge register, third stage after the pins
		rEvent.sclRise <= qSclS & ~rSclPrev;
		rEvent.sclFall <= ~qSclS & rSclPrev;
		rEvent.sda     <= qSdaS;

		if (qStart)			rEvent.busActive <= 1'b1;	// Idle -> active
		else if (qStop)		rEvent.busActive <= 1'b0;	// Active -> idle
	end
end

assign busEvent = rEvent;

// Rise and fall strobes come from one line and must be exclusive
aSclStrobeExcl: assert property (@(posedge iCLK) disable iff (iRST)
	!(busEvent.sclRise && busEvent.sclFall));

endmodule

`default_nettype wire

/* i2cPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, ACK hold time, byte union and the bus/handoff structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package i2cPkg;

	// Register bank geometry
	localparam int lpRegNum   = 16;				// Bank depth
	localparam int lpRegAw    = 4;				// Pointer / read address width

	// SDA drive timing
	localparam int lpSdaHold  = 4;				// Clocks from SCL fall to SDA OE change
	localparam int lpHoldW    = $clog2(lpSdaHold + 1);	// Hold counter width

	localparam int lpByteBits = 8;				// Data bits before the ACK clock

	// Address view of a received byte
	typedef struct packed
	{
		logic [6:0] adrs;						// 7-bit slave address
		logic       rd;							// R/W bit, 1 = read
	} i2cAdrS;

	// One byte off the bus, raw or as address + R/W
	typedef union packed
	{
		logic [7:0] raw;
		i2cAdrS     adr;
	} i2cByteU;

	// Byte handed to the register writer
	typedef struct packed
	{
		logic       first;						// Pointer byte of the transfer
		logic [7:0] data;
	} byteXferS;

	// Synchronized bus view
	typedef struct packed
	{
		logic sclRise;							// Single-cycle strobe
		logic sclFall;							// Single-cycle strobe
		logic sda;								// Synced SDA level
		logic busActive;						// Between start and stop
	} busEventS;

endpackage

`default_nettype wire
